// ==== flist.f ====
+incdir+testbench
verilog/img_pkg.sv
verilog/op_control.sv
verilog/window_scan.sv
verilog/img_buffer.sv
verilog/result_stage.sv
verilog/img_core.sv
testbench/tb_img_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then decide on the simulation log
verilator --binary -Wno-fatal -f flist.f --top-module tb_img_core -o tb_img_core \
	> build.log 2>&1 \
	&& ./obj_dir/tb_img_core > sim.log 2>&1 \
	|| { cat build.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

// ==== testbench/tb_img_model.svh ====
`ifndef TB_IMG_MODEL_SVH
`define TB_IMG_MODEL_SVH

// reference image, origin and depth kept beside the DUT
logic [img_pkg::PIX_W-1:0] m_img [img_pkg::LOAD_LEN];
int                        m_x;
int                        m_y;
int                        m_depth;

function automatic void model_reset();
	m_x     = 0;
	m_y     = 0;
	m_depth = img_pkg::DEPTH_MAX;
endfunction

// ------------------------------
// command effects
// ------------------------------
function automatic void model_apply(input img_pkg::op_mode_e mode);
	case (mode)
		img_pkg::OP_RIGHT:          if (m_x < img_pkg::ORIGIN_MAX) m_x++;
		img_pkg::OP_LEFT:           if (m_x > 0) m_x--;
		img_pkg::OP_UP:             if (m_y > 0) m_y--;
		img_pkg::OP_DOWN:           if (m_y < img_pkg::ORIGIN_MAX) m_y++;
		img_pkg::OP_REDUCE_DEPTH:   if (m_depth > img_pkg::DEPTH_MIN) m_depth = m_depth / 2;
		img_pkg::OP_INCREASE_DEPTH: if (m_depth < img_pkg::DEPTH_MAX) m_depth = m_depth * 2;
		default: ;
	endcase
endfunction

// raster order: channel, row, column
function automatic logic [img_pkg::PIX_W-1:0] pixel_at(input int ch, input int x, input int y);
	if (x < 0 || y < 0 || x >= img_pkg::IMG_W || y >= img_pkg::IMG_W) begin
		return '0;                  // zero padding
	end
	return m_img[ch * 64 + y * img_pkg::IMG_W + x];
endfunction

// slot 0..3 is (x,y) (x+1,y) (x,y+1) (x+1,y+1)
function automatic logic [img_pkg::PIX_W-1:0] expected_pixel(input int ch, input int slot);
	return pixel_at(ch, m_x + slot % 2, m_y + slot / 2);
endfunction

// gaussian 1 2 1 / 2 4 2 / 1 2 1 summed over the depth
function automatic logic [img_pkg::OUT_W-1:0] expected_conv(input int slot);
	int cx;
	int cy;
	int wx;
	int wy;
	int sum;
	cx  = m_x + slot % 2;
	cy  = m_y + slot / 2;
	sum = 0;
	for (int ch = 0; ch < m_depth; ch++) begin
		for (int dy = -1; dy <= 1; dy++) begin
			for (int dx = -1; dx <= 1; dx++) begin
				wx  = (dx == 0) ? 2 : 1;
				wy  = (dy == 0) ? 2 : 1;
				sum = sum + wx * wy * int'(pixel_at(ch, cx + dx, cy + dy));
			end
		end
	end
	return img_pkg::OUT_W'((sum + 8) >> 4);   // round then drop 4 bits
endfunction

`endif

// ==== testbench/tb_img_core.sv ====
module tb_img_core;

	`include "tb_img_model.svh"

	// cycle budget: loads with gaps, scans and single ops, times 3
	localparam int N_DISPLAY = 10;
	localparam int N_CONV    = 15;
	localparam int N_SINGLE  = 300;
	localparam int LIMIT     = 3 * (2 * img_pkg::LOAD_LEN + N_DISPLAY * 4 * 32 +
		N_CONV * 16 * 32 + N_SINGLE * 4 + 64);

	logic                          i_clk;
	logic                          i_rst_n;
	logic                          i_op_valid;
	img_pkg::op_mode_e             i_op_mode;
	logic                          o_op_ready;
	logic                          i_in_valid;
	logic [img_pkg::PIX_W-1:0]     i_in_data;
	logic                          o_in_ready;
	logic                          o_out_valid;
	logic [img_pkg::OUT_W-1:0]     o_out_data;

	integer                        seed = 66049;
	int                            cyc;
	int                            ncyc;
	int                            err_cnt;
	int                            pass_cnt;
	int                            fail_cnt;
	int                            test_start;
	int                            last_out_cyc;
	int                            rise_cyc;
	logic                          ready_q;
	logic                          loading;
	logic [img_pkg::OUT_W-1:0]     out_q [$];

	img_core uut (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.o_op_ready  (o_op_ready),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cyc++;
		if (cyc >= LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("test failed");
			$finish;
		end
	end

	// output collector, sampled mid cycle
	always @(negedge i_clk) begin
		ncyc++;
		if (o_out_valid) begin
			out_q.push_back(o_out_data);
			last_out_cyc = ncyc;
		end
		if (o_out_valid && o_op_ready) begin
			$display("o_out_valid was high while the core was idle");
			err_cnt++;
		end
		if (o_op_ready && !ready_q) rise_cyc = ncyc;
		ready_q = o_op_ready;
		if (o_in_ready && !loading) begin
			$display("o_in_ready was high while no load was running");
			err_cnt++;
		end
	end

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic check_pixel(input string name, input logic [img_pkg::PIX_W-1:0] exp,
		input logic [img_pkg::PIX_W-1:0] act);
		if (exp !== act) begin
			$display("Fail %s: expected %0d actual %0d", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_conv(input string name, input logic [img_pkg::OUT_W-1:0] exp,
		input logic [img_pkg::OUT_W-1:0] act);
		if (exp !== act) begin
			$display("Fail %s: expected %0d actual %0d", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("Fail %s count: expected %0d actual %0d", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name);
		if (err_cnt == test_start) begin
			pass_cnt++;
			$display("%s done, ok", name);
		end else begin
			fail_cnt++;
			$display("%s done, %0d errors", name, err_cnt - test_start);
		end
		test_start = err_cnt;
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	task automatic send_op(input img_pkg::op_mode_e mode);
		@(negedge i_clk);
		while (!o_op_ready) @(negedge i_clk);
		@(posedge i_clk);
		i_op_valid <= 1'b1;
		i_op_mode  <= mode;
		@(posedge i_clk);             // accept edge
		i_op_valid <= 1'b0;
		@(negedge i_clk);
		if (o_op_ready) begin
			$display("o_op_ready stayed high after an op was accepted");
			err_cnt++;
		end
	endtask

	task automatic do_single(input img_pkg::op_mode_e mode);
		send_op(mode);
		@(negedge i_clk);
		if (!o_op_ready) begin
			$display("o_op_ready not high again two cycles after a shift or depth op");
			err_cnt++;
		end
		model_apply(mode);
	endtask

	task automatic load_image();
		int  idx;
		logic v;
		idx     = 0;
		loading = 1'b1;
		send_op(img_pkg::OP_LOAD);
		while (idx < img_pkg::LOAD_LEN) begin
			@(posedge i_clk);
			v = (($random(seed) & 3) != 0);   // roughly one gap in four
			i_in_valid <= v;
			i_in_data  <= m_img[idx];
			@(negedge i_clk);
			if (v && o_in_ready) idx++;
		end
		@(posedge i_clk);
		i_in_valid <= 1'b0;
		@(negedge i_clk);
		if (!o_op_ready || o_in_ready) begin
			$display("ready signals wrong in the cycle after the last load byte");
			err_cnt++;
		end
		loading = 1'b0;
	endtask

	// waits for ready, then checks it rose right after the last output
	task automatic finish_scan();
		while (!o_op_ready) @(negedge i_clk);
		@(posedge i_clk);
		if (rise_cyc != last_out_cyc + 1) begin
			$display("o_op_ready did not return one cycle after the last output");
			err_cnt++;
		end
	endtask

	task automatic run_display(input string name);
		out_q.delete();
		send_op(img_pkg::OP_DISPLAY);
		finish_scan();
		check_count(name, 4 * m_depth, out_q.size());
		for (int i = 0; i < out_q.size() && i < 4 * m_depth; i++) begin
			check_pixel(name, expected_pixel(i / 4, i % 4), out_q[i][img_pkg::PIX_W-1:0]);
			if (out_q[i][img_pkg::OUT_W-1:img_pkg::PIX_W] !== '0) begin
				$display("Fail %s upper bits: expected 0 actual %0d", name,
					out_q[i][img_pkg::OUT_W-1:img_pkg::PIX_W]);
				err_cnt++;
			end
		end
	endtask

	task automatic run_conv(input string name);
		out_q.delete();
		send_op(img_pkg::OP_CONV);
		finish_scan();
		check_count(name, 4, out_q.size());
		for (int i = 0; i < out_q.size() && i < 4; i++) begin
			check_conv(name, expected_conv(i), out_q[i]);
		end
	endtask

	task automatic move_to(input int x, input int y, input int d);
		while (m_depth > d) do_single(img_pkg::OP_REDUCE_DEPTH);
		while (m_depth < d) do_single(img_pkg::OP_INCREASE_DEPTH);
		while (m_x < x) do_single(img_pkg::OP_RIGHT);
		while (m_x > x) do_single(img_pkg::OP_LEFT);
		while (m_y < y) do_single(img_pkg::OP_DOWN);
		while (m_y > y) do_single(img_pkg::OP_UP);
	endtask

	initial begin
		int xs [5];
		int ys [5];
		i_rst_n    = 1'b0;
		i_op_valid = 1'b0;
		i_op_mode  = img_pkg::OP_LOAD;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		loading    = 1'b0;
		ready_q    = 1'b0;
		model_reset();
		for (int k = 0; k < img_pkg::LOAD_LEN; k++) m_img[k] = $random(seed) & 8'hff;

		// reset and first ready
		repeat (8) @(posedge i_clk);
		@(negedge i_clk);
		if (o_op_ready || o_in_ready || o_out_valid) begin
			$display("outputs not low during reset");
			err_cnt++;
		end
		@(posedge i_clk);
		i_rst_n <= 1'b1;
		@(negedge i_clk);
		@(negedge i_clk);
		if (!o_op_ready) begin
			$display("o_op_ready not high in the first cycle after reset");
			err_cnt++;
		end
		finish_test("reset_handshake");

		load_image();
		run_display("load_display");
		finish_test("load_display");

		do_single(img_pkg::OP_LEFT);     // already at the low edge
		do_single(img_pkg::OP_UP);
		for (int i = 0; i < 20; i++) do_single(img_pkg::op_mode_e'(($random(seed) & 3) + 1));
		repeat (7) do_single(img_pkg::OP_RIGHT);
		repeat (7) do_single(img_pkg::OP_DOWN);
		run_display("origin_shift");
		finish_test("origin_shift");

		do_single(img_pkg::OP_INCREASE_DEPTH);
		repeat (3) do_single(img_pkg::OP_REDUCE_DEPTH);
		run_display("depth_change");
		for (int r = 0; r < 6; r++) begin
			repeat (($random(seed) & 1) + 1) begin
				do_single(($random(seed) & 1) ? img_pkg::OP_INCREASE_DEPTH
					: img_pkg::OP_REDUCE_DEPTH);
			end
			run_display("depth_change");
		end
		finish_test("depth_change");

		xs = '{0, 6, 0, 6, 0};
		ys = '{0, 6, 6, 0, 0};
		for (int d = 8; d <= 32; d = d * 2) begin
			xs[4] = ($random(seed) & 32'h7fff) % 7;
			ys[4] = ($random(seed) & 32'h7fff) % 7;
			for (int p = 0; p < 5; p++) begin
				move_to(xs[p], ys[p], d);
				run_conv("convolution");
			end
		end
		finish_test("convolution");

		$display("summary: %0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== verilog/img_core.sv ====
module img_core (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_op_valid,
	input  img_pkg::op_mode_e              i_op_mode,
	output logic                           o_op_ready,
	input  logic                           i_in_valid,
	input  logic [img_pkg::PIX_W-1:0]      i_in_data,
	output logic                           o_in_ready,
	output logic                           o_out_valid,
	output logic [img_pkg::OUT_W-1:0]      o_out_data
);

	img_pkg::wr_req_t                wr;
	img_pkg::scan_req_t              req;
	img_pkg::scan_rsp_t              rsp;
	logic                            start;
	logic                            conv;
	logic                            done;
	logic [img_pkg::COORD_W-1:0]     origin_x;
	logic [img_pkg::COORD_W-1:0]     origin_y;
	logic [img_pkg::DEPTH_W-1:0]     depth;

	// command decode, load path, origin and depth
	op_control u_op_control (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_op_valid (i_op_valid),
		.i_op_mode  (i_op_mode),
		.i_in_valid (i_in_valid),
		.i_in_data  (i_in_data),
		.i_done     (done),
		.o_op_ready (o_op_ready),
		.o_in_ready (o_in_ready),
		.o_wr       (wr),
		.o_start    (start),
		.o_conv     (conv),
		.o_origin_x (origin_x),
		.o_origin_y (origin_y),
		.o_depth    (depth)
	);

	window_scan u_window_scan (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (start),
		.i_conv     (conv),
		.i_origin_x (origin_x),
		.i_origin_y (origin_y),
		.i_depth    (depth),
		.o_req      (req)
	);

	img_buffer u_img_buffer (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_wr    (wr),
		.i_req   (req),
		.o_rsp   (rsp)
	);

	result_stage u_result_stage (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_rsp       (rsp),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_done      (done)
	);

endmodule

// ==== verilog/result_stage.sv ====
module result_stage (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  img_pkg::scan_rsp_t             i_rsp,
	output logic                           o_out_valid,
	output logic [img_pkg::OUT_W-1:0]      o_out_data,
	output logic                           o_done
);

	logic [img_pkg::ACC_W-1:0]    acc [4];
	logic [img_pkg::ACC_W-1:0]    acc_nxt [4];
	logic [img_pkg::ACC_W:0]      rounded;
	logic                         disp_hit;
	logic                         conv_hit;
	logic                         conv_last;
	logic                         first_q;
	logic                         emitting;
	logic [1:0]                   emit_cnt;
	logic [1:0]                   sel;

	// weighted contribution of one neighborhood pixel to one window slot
	function automatic logic [img_pkg::ACC_W-1:0] tap(
		input logic [1:0]                nb_col,
		input logic [1:0]                nb_row,
		input logic                      sx,
		input logic                      sy,
		input logic [img_pkg::PIX_W-1:0] pix
	);
		logic [1:0]                kc;
		logic [1:0]                kr;
		logic [img_pkg::ACC_W-1:0] term;
		kc   = nb_col - {1'b0, sx};
		kr   = nb_row - {1'b0, sy};
		term = {{(img_pkg::ACC_W - img_pkg::PIX_W){1'b0}}, pix};
		if (kc == 2'd3 || kr == 2'd3) begin
			term = '0;                  // outside this slot's 3x3 kernel
		end else begin
			if (kc == 2'd1) term = term << 1;  // 1 2 1 per axis
			if (kr == 2'd1) term = term << 1;
		end
		return term;
	endfunction

	// ------------------------------
	// accumulate and round
	// ------------------------------
	always_comb begin
		disp_hit  = i_rsp.req.valid & ~i_rsp.req.conv;
		conv_hit  = i_rsp.req.valid & i_rsp.req.conv;
		conv_last = conv_hit & i_rsp.req.last;
		for (int s = 0; s < 4; s++) begin
			acc_nxt[s] = acc[s];
			if (conv_hit) begin
				acc_nxt[s] = (first_q ? '0 : acc[s]) +
					tap(i_rsp.req.nb_col, i_rsp.req.nb_row, s[0], s[1], i_rsp.pix);
			end
		end
		// slot 0 goes out together with the final update
		sel     = emitting ? emit_cnt : 2'd0;
		rounded = {1'b0, acc_nxt[sel]} + {{(img_pkg::ACC_W - 3){1'b0}}, 4'b1000};
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
			o_done      <= 1'b0;
			emitting    <= 1'b0;
			emit_cnt    <= '0;
			first_q     <= 1'b1;
		end else begin
			o_out_valid <= disp_hit | conv_last | emitting;
			o_done      <= (disp_hit & i_rsp.req.last) | (emitting & (emit_cnt == 2'd3));
			if (conv_hit) first_q <= conv_last;   // re-arm clear for the next op
			if (conv_last) begin
				emitting <= 1'b1;
				emit_cnt <= 2'd1;
			end else if (emitting) begin
				emit_cnt <= emit_cnt + 1'b1;
				if (emit_cnt == 2'd3) emitting <= 1'b0;
			end
		end
	end

	// datapath
	always_ff @(posedge i_clk) begin
		for (int s = 0; s < 4; s++) begin
			acc[s] <= acc_nxt[s];
		end
		if (disp_hit) begin
			o_out_data <= {{(img_pkg::OUT_W - img_pkg::PIX_W){1'b0}}, i_rsp.pix};
		end else if (conv_last | emitting) begin
			o_out_data <= rounded[img_pkg::ACC_W:4];   // (sum + 8) >> 4
		end
	end

endmodule

// ==== verilog/img_buffer.sv ====
module img_buffer (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  img_pkg::wr_req_t       i_wr,
	input  img_pkg::scan_req_t     i_req,
	output img_pkg::scan_rsp_t     o_rsp
);

	logic [img_pkg::PIX_W-1:0]     mem [img_pkg::LOAD_LEN];
	logic [img_pkg::PIX_W-1:0]     rd_q;
	logic [img_pkg::ADDR_W-1:0]    addr;
	img_pkg::scan_req_t            req_q;

	// single port, loads and scans never overlap
	assign addr = i_wr.we ? i_wr.addr : i_req.addr;

	always_ff @(posedge i_clk) begin
		if (i_wr.we) begin
			mem[addr] <= i_wr.data;
		end else if (i_req.valid) begin
			rd_q <= mem[addr];
		end
	end

	// request fields ride along with the read
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			req_q <= '0;
		end else begin
			req_q <= i_req;
		end
	end

	always_comb begin
		o_rsp.req = req_q;
		o_rsp.pix = req_q.in_range ? rd_q : '0;    // padding reads as zero
	end

endmodule

// ==== verilog/window_scan.sv ====
module window_scan (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_start,
	input  logic                           i_conv,
	input  logic [img_pkg::COORD_W-1:0]    i_origin_x,
	input  logic [img_pkg::COORD_W-1:0]    i_origin_y,
	input  logic [img_pkg::DEPTH_W-1:0]    i_depth,
	output img_pkg::scan_req_t             o_req
);

	logic                           busy;
	logic                           go;
	logic                           last;
	logic [img_pkg::CH_W-1:0]       ch;
	logic [img_pkg::CH_W-1:0]       cur_ch;
	logic [3:0]                     pos;
	logic [3:0]                     cur_pos;
	logic [3:0]                     pos_end;
	logic [1:0]                     dcol;
	logic [1:0]                     drow;
	logic [img_pkg::COORD_W+1:0]    px;       // one spare bit each side of the image
	logic [img_pkg::COORD_W+1:0]    py;
	img_pkg::scan_req_t             req_nxt;

	// ------------------------------
	// request generation
	// ------------------------------
	always_comb begin
		// the start cycle already issues position 0 of channel 0
		cur_ch  = i_start ? '0 : ch;
		cur_pos = i_start ? '0 : pos;
		go      = i_start | busy;
		pos_end = i_conv ? 4'd15 : 4'd3;

		if (i_conv) begin
			dcol = cur_pos[1:0];        // 4x4 neighborhood, row major
			drow = cur_pos[3:2];
		end else begin
			dcol = {1'b0, cur_pos[0]};  // 2x2 window in slot order
			drow = {1'b0, cur_pos[1]};
		end

		// neighborhood starts one up and one left of the origin
		px = {2'b00, i_origin_x} + {3'b000, dcol} - {4'b0000, i_conv};
		py = {2'b00, i_origin_y} + {3'b000, drow} - {4'b0000, i_conv};

		last = ({1'b0, cur_ch} == i_depth - 1'b1) && (cur_pos == pos_end);

		req_nxt.valid    = go;
		req_nxt.conv     = i_conv;
		req_nxt.in_range = (px[4:3] == 2'b00) && (py[4:3] == 2'b00);   // -1 wraps high
		req_nxt.addr     = {cur_ch, py[2:0], px[2:0]};
		req_nxt.nb_col   = dcol;
		req_nxt.nb_row   = drow;
		req_nxt.slot     = i_conv ? 2'd0 : cur_pos[1:0];
		req_nxt.last     = go & last;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy  <= 1'b0;
			ch    <= '0;
			pos   <= '0;
			o_req <= '0;
		end else begin
			o_req <= req_nxt;
			if (go) begin
				busy <= ~last;
				if (cur_pos == pos_end) begin
					pos <= '0;
					ch  <= cur_ch + 1'b1;  // next channel
				end else begin
					pos <= cur_pos + 1'b1;
					ch  <= cur_ch;
				end
			end
		end
	end

endmodule

// ==== verilog/op_control.sv ====
module op_control (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_op_valid,
	input  img_pkg::op_mode_e              i_op_mode,
	input  logic                           i_in_valid,
	input  logic [img_pkg::PIX_W-1:0]      i_in_data,
	input  logic                           i_done,
	output logic                           o_op_ready,
	output logic                           o_in_ready,
	output img_pkg::wr_req_t               o_wr,
	output logic                           o_start,
	output logic                           o_conv,
	output logic [img_pkg::COORD_W-1:0]    o_origin_x,
	output logic [img_pkg::COORD_W-1:0]    o_origin_y,
	output logic [img_pkg::DEPTH_W-1:0]    o_depth
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SINGLE,
		ST_BUSY
	} state_e;

	state_e                       state;
	state_e                       state_nxt;
	img_pkg::op_mode_e            op_q;
	logic                         ready_nxt;
	logic                         accept;
	logic                         load_last;
	logic [img_pkg::ADDR_W-1:0]   load_cnt;

	assign accept     = i_op_valid & o_op_ready;
	assign o_in_ready = (state == ST_LOAD);
	assign load_last  = o_wr.we & (load_cnt == img_pkg::LOAD_LAST);

	// raster layout, byte index is the buffer address
	always_comb begin
		o_wr.we   = o_in_ready & i_in_valid;
		o_wr.addr = load_cnt;
		o_wr.data = i_in_data;
	end

	// ------------------------------
	// next state / ready
	// ------------------------------
	always_comb begin
		state_nxt = state;
		ready_nxt = o_op_ready;
		case (state)
			ST_IDLE: begin
				ready_nxt = ~accept;        // first idle cycle after reset raises it
				if (accept) begin
					case (i_op_mode)
						img_pkg::OP_LOAD:    state_nxt = ST_LOAD;
						img_pkg::OP_DISPLAY: state_nxt = ST_BUSY;
						img_pkg::OP_CONV:    state_nxt = ST_BUSY;
						default:             state_nxt = ST_SINGLE;
					endcase
				end
			end
			ST_LOAD: begin
				if (load_last) begin
					state_nxt = ST_IDLE;
					ready_nxt = 1'b1;
				end
			end
			ST_SINGLE: begin
				state_nxt = ST_IDLE;
				ready_nxt = 1'b1;
			end
			ST_BUSY: begin
				if (i_done) begin       // done arrives with the last output
					state_nxt = ST_IDLE;
					ready_nxt = 1'b1;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= ST_IDLE;
			o_op_ready <= 1'b0;
			o_start    <= 1'b0;
			o_conv     <= 1'b0;
			op_q       <= img_pkg::OP_LOAD;
			load_cnt   <= '0;
			o_origin_x <= '0;
			o_origin_y <= '0;
			o_depth    <= img_pkg::DEPTH_MAX;
		end else begin
			state      <= state_nxt;
			o_op_ready <= ready_nxt;
			o_start    <= accept & ((i_op_mode == img_pkg::OP_DISPLAY) |
				(i_op_mode == img_pkg::OP_CONV));
			if (accept) begin
				op_q     <= i_op_mode;
				o_conv   <= (i_op_mode == img_pkg::OP_CONV);
				load_cnt <= '0;
			end else if (o_wr.we) begin
				load_cnt <= load_cnt + 1'b1;
			end

			// saturating origin / depth updates
			if (state == ST_SINGLE) begin
				case (op_q)
					img_pkg::OP_RIGHT: if (o_origin_x != img_pkg::ORIGIN_MAX) o_origin_x <= o_origin_x + 1'b1;
					img_pkg::OP_LEFT:  if (o_origin_x != '0) o_origin_x <= o_origin_x - 1'b1;
					img_pkg::OP_UP:    if (o_origin_y != '0) o_origin_y <= o_origin_y - 1'b1;
					img_pkg::OP_DOWN:  if (o_origin_y != img_pkg::ORIGIN_MAX) o_origin_y <= o_origin_y + 1'b1;
					img_pkg::OP_REDUCE_DEPTH:   if (o_depth != img_pkg::DEPTH_MIN) o_depth <= o_depth >> 1;
					img_pkg::OP_INCREASE_DEPTH: if (o_depth != img_pkg::DEPTH_MAX) o_depth <= o_depth << 1;
					default: ;                  // unknown codes change nothing
				endcase
			end
		end
	end

endmodule

// ==== verilog/img_pkg.sv ====
package img_pkg;

	// ------------------------------
	// image geometry
	// ------------------------------
	localparam int IMG_W    = 8;
	localparam int COORD_W  = 3;                // origin x / y
	localparam int CH_W     = 5;                // channel index, 32 channels
	localparam int DEPTH_W  = 6;                // holds 8, 16 or 32
	localparam int PIX_W    = 8;
	localparam int ADDR_W   = 11;
	localparam int LOAD_LEN = 2048;             // 32 ch x 8 rows x 8 cols

	localparam logic [COORD_W-1:0] ORIGIN_MAX = 3'd6;
	localparam logic [DEPTH_W-1:0] DEPTH_MIN  = 6'd8;
	localparam logic [DEPTH_W-1:0] DEPTH_MAX  = 6'd32;
	localparam logic [ADDR_W-1:0]  LOAD_LAST  = ADDR_W'(LOAD_LEN - 1);

	// accumulator covers 32 ch x weight sum 16 x 255
	localparam int ACC_W = 17;
	localparam int OUT_W = 14;

	// ------------------------------
	// command codes
	// ------------------------------
	// 9 and 10 were median / sobel, now retired
	typedef enum logic [3:0] {
		OP_LOAD           = 4'd0,
		OP_RIGHT          = 4'd1,
		OP_LEFT           = 4'd2,
		OP_UP             = 4'd3,
		OP_DOWN           = 4'd4,
		OP_REDUCE_DEPTH   = 4'd5,
		OP_INCREASE_DEPTH = 4'd6,
		OP_DISPLAY        = 4'd7,
		OP_CONV           = 4'd8
	} op_mode_e;

	// ------------------------------
	// pipeline payloads
	// ------------------------------
	typedef struct packed {
		logic              valid;
		logic              conv;
		logic              in_range;     // low for zero padding
		logic [ADDR_W-1:0] addr;
		logic [1:0]        nb_col;       // offset inside 4x4 neighborhood
		logic [1:0]        nb_row;
		logic [1:0]        slot;         // display window slot
		logic              last;
	} scan_req_t;

	typedef struct packed {
		scan_req_t        req;
		logic [PIX_W-1:0] pix;
	} scan_rsp_t;

	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [PIX_W-1:0]  data;
	} wr_req_t;

endpackage
